//--- compile.f
+incdir+hdl
hdl/core_pkg.sv
hdl/stage_if.sv
hdl/regfile.sv
hdl/decode.sv
hdl/execute.sv
hdl/result.sv
hdl/core.sv
sim/tb_memory.sv
sim/core_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS := --binary --timing --assert
TOP := core_tb
FILELIST := compile.f
OBJ_DIR := obj_dir
BIN := $(OBJ_DIR)/V$(TOP)
LOG := sim.log

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := hdl/core_consts.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx 'STATUS: PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/core_tb.sv
`timescale 1ns/100ps
`include "core_consts.svh"

module core_tb;
	import core_pkg::*;

	logic clk;
	logic reset;
	logic ireq_valid;
	word_t ireq_addr;
	logic iresp_data_ok;
	logic [31:0] iresp_data;
	logic dreq_valid;
	logic dreq_write;
	word_t dreq_addr;
	word_t dreq_data;
	logic dresp_data_ok;
	word_t dresp_data;

	logic [31:0] prog [$];
	word_t obs_addr [$];
	word_t obs_data [$];
	word_t exp_addr [$];
	word_t exp_data [$];
	int exp_tag [$];
	word_t skip_addr [$];
	int errors;
	int reset_errors;
	int cycles;
	int limit;
	int passed;
	int failed;
	int e0;
	bit timed_out;

	core dut (
		.clk(clk),
		.reset(reset),
		.ireq_valid(ireq_valid),
		.ireq_addr(ireq_addr),
		.iresp_data_ok(iresp_data_ok),
		.iresp_data(iresp_data),
		.dreq_valid(dreq_valid),
		.dreq_write(dreq_write),
		.dreq_addr(dreq_addr),
		.dreq_data(dreq_data),
		.dresp_data_ok(dresp_data_ok),
		.dresp_data(dresp_data)
	);

	tb_memory mem (
		.clk(clk),
		.reset(reset),
		.ireq_valid(ireq_valid),
		.ireq_addr(ireq_addr),
		.iresp_data_ok(iresp_data_ok),
		.iresp_data(iresp_data),
		.dreq_valid(dreq_valid),
		.dreq_write(dreq_write),
		.dreq_addr(dreq_addr),
		.dreq_data(dreq_data),
		.dresp_data_ok(dresp_data_ok),
		.dresp_data(dresp_data)
	);

	always #10 clk = ~clk;

	always @(posedge clk) cycles++;

	// record completed stores and catch any load issued before the first store
	always @(negedge clk) begin
		if (!reset && dreq_valid) begin
			if (obs_addr.size() == 0) begin
				assert (dreq_write && dreq_addr === exp_addr[0]) else begin
					$display("data request other than the first store seen at %h", dreq_addr);
					errors++;
					reset_errors++;
				end
			end
			if (dreq_write && dresp_data_ok) begin
				obs_addr.push_back(dreq_addr);
				obs_data.push_back(dreq_data);
			end
		end
	end

	task automatic emit_alu(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
		instr_u w;
		w.r_fields.funct7 = f7;
		w.r_fields.rs2 = rs2[4:0];
		w.r_fields.rs1 = rs1[4:0];
		w.r_fields.funct3 = f3;
		w.r_fields.rd = rd[4:0];
		w.r_fields.opcode = `OPC_OP;
		prog.push_back(w);
	endtask

	// I-type shares the r view with imm in funct7 and rs2
	task automatic emit_itype(logic [6:0] opc, logic [2:0] f3, int rd, int rs1, int imm);
		instr_u w;
		w.r_fields.funct7 = imm[11:5];
		w.r_fields.rs2 = imm[4:0];
		w.r_fields.rs1 = rs1[4:0];
		w.r_fields.funct3 = f3;
		w.r_fields.rd = rd[4:0];
		w.r_fields.opcode = opc;
		prog.push_back(w);
	endtask

	task automatic emit_sd(int rs2, int off, int rs1);
		instr_u w;
		w.s_fields.imm_hi = off[11:5];
		w.s_fields.rs2 = rs2[4:0];
		w.s_fields.rs1 = rs1[4:0];
		w.s_fields.funct3 = `F3_DOUBLE;
		w.s_fields.imm_lo = off[4:0];
		w.s_fields.opcode = `OPC_STORE;
		prog.push_back(w);
	endtask

	task automatic emit_beq(int rs1, int rs2, int off);
		instr_u w;
		w.s_fields.imm_hi = {off[12], off[10:5]};
		w.s_fields.rs2 = rs2[4:0];
		w.s_fields.rs1 = rs1[4:0];
		w.s_fields.funct3 = `F3_BEQ;
		w.s_fields.imm_lo = {off[4:1], off[11]};
		w.s_fields.opcode = `OPC_BRANCH;
		prog.push_back(w);
	endtask

	task automatic emit_upper(logic [6:0] opc, int rd, logic [19:0] up);
		instr_u w;
		w.r_fields.funct7 = up[19:13];
		w.r_fields.rs2 = up[12:8];
		w.r_fields.rs1 = up[7:3];
		w.r_fields.funct3 = up[2:0];
		w.r_fields.rd = rd[4:0];
		w.r_fields.opcode = opc;
		prog.push_back(w);
	endtask

	task automatic emit_jal(int rd, int off);
		emit_upper(`OPC_JAL, rd, {off[20], off[10:1], off[11], off[19:12]});
	endtask

	task automatic expect_store(int tag, int off, word_t data);
		exp_tag.push_back(tag);
		exp_addr.push_back(64'h100 + word_t'(off));
		exp_data.push_back(data);
	endtask

	task automatic build_program();
		word_t a;
		word_t b;
		word_t v;
		word_t link;
		a = 64'd100;
		b = 64'd0 - 64'd23;
		emit_itype(`OPC_OP_IMM, `F3_ADD_SUB, 1, 0, 256);
		emit_itype(`OPC_OP_IMM, `F3_ADD_SUB, 2, 0, 100);
		emit_itype(`OPC_OP_IMM, `F3_ADD_SUB, 3, 0, -23);
		emit_upper(`OPC_LUI, 4, 20'h12345);
		emit_upper(`OPC_LUI, 23, 20'h80000);
		emit_alu(`F7_BASE, `F3_ADD_SUB, 5, 2, 3);
		emit_sd(5, 0, 1);
		expect_store(2, 0, a + b);
		emit_alu(`F7_SUB, `F3_ADD_SUB, 6, 2, 3);
		emit_sd(6, 8, 1);
		expect_store(2, 8, a - b);
		emit_alu(`F7_BASE, `F3_AND, 7, 2, 3);
		emit_sd(7, 16, 1);
		expect_store(2, 16, a & b);
		emit_alu(`F7_BASE, `F3_OR, 8, 2, 3);
		emit_sd(8, 24, 1);
		expect_store(2, 24, a | b);
		emit_alu(`F7_BASE, `F3_XOR, 9, 2, 3);
		emit_sd(9, 32, 1);
		expect_store(2, 32, a ^ b);
		emit_sd(4, 40, 1);
		expect_store(2, 40, 64'h0000_0000_1234_5000);
		emit_sd(23, 48, 1);
		expect_store(2, 48, 64'hffff_ffff_8000_0000);
		emit_sd(3, 56, 1);
		expect_store(2, 56, b);
		// dependent chain where each result feeds the next
		emit_itype(`OPC_OP_IMM, `F3_ADD_SUB, 10, 0, 5);
		emit_alu(`F7_BASE, `F3_ADD_SUB, 11, 10, 10);
		emit_alu(`F7_BASE, `F3_ADD_SUB, 12, 11, 10);
		emit_alu(`F7_SUB, `F3_ADD_SUB, 13, 12, 11);
		emit_alu(`F7_BASE, `F3_XOR, 14, 13, 12);
		emit_sd(14, 64, 1);
		expect_store(3, 64, 64'd5 ^ 64'd15);
		emit_sd(12, 72, 1);
		expect_store(3, 72, 64'd15);
		emit_itype(`OPC_OP_IMM, `F3_ADD_SUB, 15, 14, 7);
		emit_sd(15, 80, 1);
		expect_store(3, 80, (64'd5 ^ 64'd15) + 64'd7);
		// load then immediate use
		emit_itype(`OPC_LOAD, `F3_DOUBLE, 16, 1, 256);
		emit_alu(`F7_BASE, `F3_ADD_SUB, 17, 16, 2);
		emit_sd(17, 88, 1);
		v = mem.fill_pattern(64'h200);
		expect_store(4, 88, v + a);
		emit_itype(`OPC_LOAD, `F3_DOUBLE, 18, 1, 0);
		emit_alu(`F7_BASE, `F3_ADD_SUB, 19, 18, 18);
		emit_sd(19, 96, 1);
		expect_store(4, 96, (a + b) + (a + b));
		// taken branch skips two stores
		emit_itype(`OPC_OP_IMM, `F3_ADD_SUB, 20, 0, 9);
		emit_itype(`OPC_OP_IMM, `F3_ADD_SUB, 21, 0, 9);
		emit_beq(20, 21, 12);
		emit_sd(20, 104, 1);
		emit_sd(20, 112, 1);
		skip_addr.push_back(64'h100 + 64'd104);
		skip_addr.push_back(64'h100 + 64'd112);
		emit_sd(21, 120, 1);
		expect_store(5, 120, 64'd9);
		emit_beq(20, 2, 8);
		emit_sd(2, 128, 1);
		expect_store(5, 128, a);
		link = word_t'(prog.size()) * 64'd4 + 64'd4;
		emit_jal(22, 12);
		emit_sd(20, 136, 1);
		emit_sd(20, 144, 1);
		skip_addr.push_back(64'h100 + 64'd136);
		skip_addr.push_back(64'h100 + 64'd144);
		emit_sd(22, 152, 1);
		expect_store(5, 152, link);
		emit_jal(0, 0);
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		assert (got === exp) else begin
			$display("FAIL %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_tagged(int tag);
		int idx;
		for (int k = 0; k < exp_addr.size(); k++) begin
			if (exp_tag[k] == tag) begin
				idx = -1;
				for (int j = 0; j < obs_addr.size(); j++) begin
					if (idx < 0 && obs_addr[j] === exp_addr[k]) idx = j;
				end
				assert (idx >= 0) else begin
					$display("no store to address %h was seen", exp_addr[k]);
					errors++;
				end
				if (idx >= 0) begin
					check_word($sformatf("dreq_data @%h", exp_addr[k]), obs_data[idx],
						exp_data[k]);
				end
			end
		end
	endtask

	task automatic check_skipped();
		foreach (skip_addr[k]) begin
			foreach (obs_addr[j]) begin
				assert (obs_addr[j] !== skip_addr[k]) else begin
					$display("store to skipped address %h was executed", skip_addr[k]);
					errors++;
				end
			end
		end
	endtask

	task automatic check_sequence();
		int n;
		assert (obs_addr.size() == exp_addr.size()) else begin
			$display("saw %0d stores where %0d were predicted", obs_addr.size(),
				exp_addr.size());
			errors++;
		end
		n = (obs_addr.size() < exp_addr.size()) ? obs_addr.size() : exp_addr.size();
		for (int k = 0; k < n; k++) begin
			check_word($sformatf("dreq_addr #%0d", k), obs_addr[k], exp_addr[k]);
			check_word($sformatf("dreq_data #%0d", k), obs_data[k], exp_data[k]);
		end
	endtask

	task automatic report(int num, string name, int n_err);
		if (n_err == 0) begin
			passed++;
			$display("test %0d %s: ok", num, name);
		end else begin
			failed++;
			$display("test %0d %s: %0d errors", num, name, n_err);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		errors = 0;
		reset_errors = 0;
		cycles = 0;
		passed = 0;
		failed = 0;
		timed_out = 1'b0;
		// memory clears itself at time zero
		#1;
		build_program();
		foreach (prog[k]) mem.imem[k] = prog[k];
		limit = 20 * prog.size() + 200;

		@(posedge clk);
		@(posedge clk);
		#2 reset = 1'b0;
		@(negedge clk);
		assert (ireq_valid === 1'b1) else begin
			$display("FAIL ireq_valid: got %h expected %h", ireq_valid, 1'b1);
			errors++;
			reset_errors++;
		end
		assert (ireq_addr === `CORE_RESET_PC) else begin
			$display("FAIL ireq_addr: got %h expected %h", ireq_addr, `CORE_RESET_PC);
			errors++;
			reset_errors++;
		end
		assert (dreq_valid === 1'b0) else begin
			$display("FAIL dreq_valid: got %h expected %h", dreq_valid, 1'b0);
			errors++;
			reset_errors++;
		end

		while (obs_addr.size() < exp_addr.size() && cycles < limit) @(posedge clk);
		if (cycles >= limit) begin
			timed_out = 1'b1;
			$display("timeout: %0d of %0d stores done after %0d cycles", obs_addr.size(),
				exp_addr.size(), cycles);
		end else begin
			// room for any stray store to show up
			repeat (40) @(posedge clk);
		end

		report(1, "reset state", reset_errors);
		e0 = errors;
		check_tagged(2);
		report(2, "alu ops", errors - e0);
		e0 = errors;
		check_tagged(3);
		report(3, "forwarding", errors - e0);
		e0 = errors;
		check_tagged(4);
		report(4, "load use", errors - e0);
		e0 = errors;
		check_tagged(5);
		check_skipped();
		report(5, "branch and jump", errors - e0);
		e0 = errors;
		check_sequence();
		report(6, "store sequence", errors - e0);

		$display("tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
		if (!timed_out && failed == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end
endmodule

//--- sim/tb_memory.sv
`timescale 1ns/100ps

module tb_memory (
	input logic clk,
	input logic reset,
	input logic ireq_valid,
	input core_pkg::word_t ireq_addr,
	output logic iresp_data_ok,
	output logic [31:0] iresp_data,
	input logic dreq_valid,
	input logic dreq_write,
	input core_pkg::word_t dreq_addr,
	input core_pkg::word_t dreq_data,
	output logic dresp_data_ok,
	output core_pkg::word_t dresp_data
);
	import core_pkg::*;

	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 512;

	logic [31:0] imem [IMEM_WORDS];
	word_t dmem [DMEM_WORDS];
	integer seed;
	int i_wait;
	int d_wait;
	logic i_took;
	logic d_took;
	logic d_wr;
	logic rst_q;
	word_t wr_addr;
	word_t wr_data;

	// every data word starts out distinct
	function automatic word_t fill_pattern(word_t addr);
		return {addr[31:0] ^ 32'ha5c3_0f00, ~addr[31:0]};
	endfunction

	function int next_delay();
		return $unsigned($random(seed)) % 4;
	endfunction

	initial begin
		seed = 44;
		iresp_data_ok = 1'b0;
		iresp_data = '0;
		dresp_data_ok = 1'b0;
		dresp_data = '0;
		i_took = 1'b0;
		d_took = 1'b0;
		d_wr = 1'b0;
		rst_q = 1'b1;
		i_wait = 0;
		d_wait = 0;
		for (int n = 0; n < IMEM_WORDS; n++) begin
			imem[n] = '0;
		end
		for (int n = 0; n < DMEM_WORDS; n++) begin
			dmem[n] = fill_pattern(word_t'(n) << 3);
		end
	end

	// a transfer completes on the next rising edge
	always @(negedge clk) begin
		i_took = ireq_valid && iresp_data_ok;
		d_took = dreq_valid && dresp_data_ok;
		d_wr = d_took && dreq_write;
		wr_addr = dreq_addr;
		wr_data = dreq_data;
	end

	always @(posedge clk) begin
		rst_q = reset;
		if (d_wr) begin
			dmem[wr_addr[11:3]] = wr_data;
		end
		#2;
		if (rst_q) begin
			iresp_data_ok = 1'b0;
			dresp_data_ok = 1'b0;
			i_wait = next_delay();
			d_wait = next_delay();
		end else begin
			if (i_took) i_wait = next_delay();
			if (d_took) d_wait = next_delay();
			if (ireq_valid && i_wait == 0) begin
				iresp_data_ok = 1'b1;
				iresp_data = imem[ireq_addr[9:2]];
			end else begin
				iresp_data_ok = 1'b0;
				if (ireq_valid) i_wait--;
			end
			if (dreq_valid && d_wait == 0) begin
				dresp_data_ok = 1'b1;
				dresp_data = dreq_write ? '0 : dmem[dreq_addr[11:3]];
			end else begin
				dresp_data_ok = 1'b0;
				if (dreq_valid) d_wait--;
			end
		end
	end
endmodule

//--- hdl/core.sv
`timescale 1ns/100ps

module core (
	input logic clk,
	input logic reset,
	output logic ireq_valid,
	output core_pkg::word_t ireq_addr,
	input logic iresp_data_ok,
	input logic [31:0] iresp_data,
	output logic dreq_valid,
	output logic dreq_write,
	output core_pkg::word_t dreq_addr,
	output core_pkg::word_t dreq_data,
	input logic dresp_data_ok,
	input core_pkg::word_t dresp_data
);
	import core_pkg::*;

	logic stall;
	logic fetch_wait;
	logic busy;
	logic redirect;
	word_t redirect_pc;
	reg_addr_t ra1;
	reg_addr_t ra2;
	word_t rd1;
	word_t rd2;
	logic wb_valid;
	reg_addr_t wb_rd;
	word_t wb_data;

	stage_if dec_ex ();
	stage_if ex_res ();

	// any bus wait freezes every stage
	assign stall = busy || fetch_wait;

	decode u_decode (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.ireq_valid(ireq_valid),
		.ireq_addr(ireq_addr),
		.iresp_data_ok(iresp_data_ok),
		.iresp_data(iresp_data),
		.ra1(ra1),
		.ra2(ra2),
		.rd1(rd1),
		.rd2(rd2),
		.dec_ex(dec_ex.src),
		.fetch_wait(fetch_wait)
	);

	execute u_execute (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.dec_ex(dec_ex.dst),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.ex_res(ex_res.src)
	);

	result u_result (
		.clk(clk),
		.reset(reset),
		.ex_res(ex_res.dst),
		.dreq_valid(dreq_valid),
		.dreq_write(dreq_write),
		.dreq_addr(dreq_addr),
		.dreq_data(dreq_data),
		.dresp_data_ok(dresp_data_ok),
		.dresp_data(dresp_data),
		.busy(busy),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.ra1(ra1),
		.ra2(ra2),
		.rd1(rd1),
		.rd2(rd2),
		.we(wb_valid),
		.wa(wb_rd),
		.wd(wb_data)
	);
endmodule

//--- hdl/result.sv
`timescale 1ns/100ps

module result (
	input logic clk,
	input logic reset,
	stage_if.dst ex_res,
	output logic dreq_valid,
	output logic dreq_write,
	output core_pkg::word_t dreq_addr,
	output core_pkg::word_t dreq_data,
	input logic dresp_data_ok,
	input core_pkg::word_t dresp_data,
	output logic busy,
	output logic wb_valid,
	output core_pkg::reg_addr_t wb_rd,
	output core_pkg::word_t wb_data
);
	import core_pkg::*;

	logic is_load;
	logic is_mem;
	logic alu_write;
	logic done_q;
	logic done_hit;
	logic xfer;
	word_t done_pc;
	word_t load_q;

	assign is_load = (ex_res.op == OP_LD);
	assign is_mem = is_load || (ex_res.op == OP_SD);
	assign alu_write = (ex_res.op == OP_ADD) || (ex_res.op == OP_SUB) ||
		(ex_res.op == OP_AND) || (ex_res.op == OP_OR) || (ex_res.op == OP_XOR) ||
		(ex_res.op == OP_ADDI) || (ex_res.op == OP_LUI) || (ex_res.op == OP_JAL);

	// access already finished but the pipeline is still holding this op
	assign done_hit = done_q && is_mem && (done_pc == ex_res.pc);

	assign dreq_valid = is_mem && !done_hit;
	assign dreq_write = (ex_res.op == OP_SD);
	assign dreq_addr = ex_res.a;
	assign dreq_data = ex_res.b;
	assign xfer = dreq_valid && dresp_data_ok;

	assign busy = dreq_valid && !dresp_data_ok;

	assign wb_valid = alu_write || (is_load && (xfer || done_hit));
	assign wb_rd = ex_res.rd;
	assign wb_data = !is_load ? ex_res.a : done_hit ? load_q : dresp_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			done_q <= 1'b0;
		end else if (xfer) begin
			done_q <= 1'b1;
		end else if (!done_hit) begin
			done_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (xfer) begin
			done_pc <= ex_res.pc;
			load_q <= dresp_data;
		end
	end
endmodule

//--- hdl/execute.sv
`timescale 1ns/100ps

module execute (
	input logic clk,
	input logic reset,
	input logic stall,
	stage_if.dst dec_ex,
	input logic wb_valid,
	input core_pkg::reg_addr_t wb_rd,
	input core_pkg::word_t wb_data,
	output logic redirect,
	output core_pkg::word_t redirect_pc,
	stage_if.src ex_res
);
	import core_pkg::*;

	word_t src_a;
	word_t src_b;
	word_t alu_out;
	logic fwd_a;
	logic fwd_b;
	logic taken;

	// only the result stage can be ahead of us
	assign fwd_a = wb_valid && (wb_rd != '0) && (wb_rd == dec_ex.rs1);
	assign fwd_b = wb_valid && (wb_rd != '0) && (wb_rd == dec_ex.rs2);
	assign src_a = fwd_a ? wb_data : dec_ex.a;
	assign src_b = fwd_b ? wb_data : dec_ex.b;

	always_comb begin
		alu_out = '0;
		taken = 1'b0;
		case (dec_ex.op)
			OP_ADD: alu_out = src_a + src_b;
			OP_SUB: alu_out = src_a - src_b;
			OP_AND: alu_out = src_a & src_b;
			OP_OR: alu_out = src_a | src_b;
			OP_XOR: alu_out = src_a ^ src_b;
			OP_ADDI, OP_LD, OP_SD: alu_out = src_a + dec_ex.imm;
			OP_LUI: alu_out = dec_ex.imm;
			OP_BEQ: taken = (src_a == src_b);
			OP_JAL: begin
				// link value
				alu_out = dec_ex.pc + 64'd4;
				taken = 1'b1;
			end
			default: alu_out = '0;
		endcase
	end

	assign redirect = taken;
	assign redirect_pc = dec_ex.pc + dec_ex.imm;

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_res.op <= OP_NONE;
		end else if (!stall) begin
			ex_res.op <= dec_ex.op;
		end
	end

	// a carries the result or address and b the store data
	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_res.rd <= dec_ex.rd;
			ex_res.a <= alu_out;
			ex_res.b <= src_b;
			ex_res.pc <= dec_ex.pc;
		end
	end
endmodule

//--- hdl/decode.sv
`timescale 1ns/100ps
`include "core_consts.svh"

module decode (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic redirect,
	input core_pkg::word_t redirect_pc,
	output logic ireq_valid,
	output core_pkg::word_t ireq_addr,
	input logic iresp_data_ok,
	input logic [31:0] iresp_data,
	output core_pkg::reg_addr_t ra1,
	output core_pkg::reg_addr_t ra2,
	input core_pkg::word_t rd1,
	input core_pkg::word_t rd2,
	stage_if.src dec_ex,
	output logic fetch_wait
);
	import core_pkg::*;

	word_t pc;
	word_t imm;
	logic buf_valid;
	logic [31:0] buf_word;
	instr_u instr;
	op_t op;
	reg_addr_t rd;
	logic [19:0] upper;

	// a word that arrives while the pipeline holds is parked in the buffer
	assign ireq_valid = !buf_valid;
	assign ireq_addr = pc;
	assign fetch_wait = !buf_valid && !iresp_data_ok;

	assign instr = buf_valid ? buf_word : iresp_data;
	assign ra1 = instr.r_fields.rs1;
	assign ra2 = instr.r_fields.rs2;
	assign upper = {instr.r_fields.funct7, instr.r_fields.rs2, instr.r_fields.rs1,
		instr.r_fields.funct3};

	always_comb begin
		op = OP_NONE;
		imm = {{52{instr.r_fields.funct7[6]}}, instr.r_fields.funct7, instr.r_fields.rs2};
		case (instr.r_fields.opcode)
			`OPC_OP: begin
				case ({instr.r_fields.funct7, instr.r_fields.funct3})
					{`F7_BASE, `F3_ADD_SUB}: op = OP_ADD;
					{`F7_SUB, `F3_ADD_SUB}: op = OP_SUB;
					{`F7_BASE, `F3_XOR}: op = OP_XOR;
					{`F7_BASE, `F3_OR}: op = OP_OR;
					{`F7_BASE, `F3_AND}: op = OP_AND;
					default: op = OP_NONE;
				endcase
			end
			`OPC_OP_IMM: if (instr.r_fields.funct3 == `F3_ADD_SUB) op = OP_ADDI;
			`OPC_LOAD: if (instr.r_fields.funct3 == `F3_DOUBLE) op = OP_LD;
			`OPC_LUI: begin
				op = OP_LUI;
				imm = {{32{upper[19]}}, upper, 12'b0};
			end
			`OPC_STORE: begin
				if (instr.s_fields.funct3 == `F3_DOUBLE) op = OP_SD;
				imm = {{52{instr.s_fields.imm_hi[6]}}, instr.s_fields.imm_hi,
					instr.s_fields.imm_lo};
			end
			`OPC_BRANCH: begin
				if (instr.s_fields.funct3 == `F3_BEQ) op = OP_BEQ;
				imm = {{51{instr.s_fields.imm_hi[6]}}, instr.s_fields.imm_hi[6],
					instr.s_fields.imm_lo[0], instr.s_fields.imm_hi[5:0],
					instr.s_fields.imm_lo[4:1], 1'b0};
			end
			`OPC_JAL: begin
				op = OP_JAL;
				imm = {{43{upper[19]}}, upper[19], upper[7:0], upper[8], upper[18:9], 1'b0};
			end
			default: op = OP_NONE;
		endcase
		// rd bits are immediate bits for these
		rd = (op == OP_SD || op == OP_BEQ || op == OP_NONE) ? '0 : instr.r_fields.rd;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `CORE_RESET_PC;
			buf_valid <= 1'b0;
			dec_ex.op <= OP_NONE;
		end else if (!stall) begin
			pc <= redirect ? redirect_pc : pc + 64'd4;
			buf_valid <= 1'b0;
			dec_ex.op <= redirect ? OP_NONE : op;
		end else if (iresp_data_ok && !buf_valid) begin
			buf_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (stall && iresp_data_ok && !buf_valid) begin
			buf_word <= iresp_data;
		end
		if (!stall) begin
			dec_ex.rd <= rd;
			dec_ex.rs1 <= instr.r_fields.rs1;
			dec_ex.rs2 <= instr.r_fields.rs2;
			dec_ex.a <= rd1;
			dec_ex.b <= rd2;
			dec_ex.imm <= imm;
			dec_ex.pc <= pc;
		end
	end
endmodule

//--- hdl/regfile.sv
`timescale 1ns/100ps

module regfile (
	input logic clk,
	input logic reset,
	input core_pkg::reg_addr_t ra1,
	input core_pkg::reg_addr_t ra2,
	output core_pkg::word_t rd1,
	output core_pkg::word_t rd2,
	input logic we,
	input core_pkg::reg_addr_t wa,
	input core_pkg::word_t wd
);
	import core_pkg::*;

	word_t [31:0] regs;
	logic wr_en;

	// x0 never written
	assign wr_en = we && (wa != '0);

	// same-cycle write is visible on the read ports
	assign rd1 = (ra1 == '0) ? '0 : (wr_en && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (wr_en && wa == ra2) ? wd : regs[ra2];

	always_ff @(posedge clk) begin
		if (reset) begin
			regs <= '0;
		end else if (wr_en) begin
			regs[wa] <= wd;
		end
	end
endmodule

//--- hdl/stage_if.sv
`timescale 1ns/100ps

interface stage_if;
	import core_pkg::*;

	op_t op;
	reg_addr_t rd;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t a;
	word_t b;
	word_t imm;
	word_t pc;

	modport src (
		output op,
		output rd,
		output rs1,
		output rs2,
		output a,
		output b,
		output imm,
		output pc
	);

	modport dst (
		input op,
		input rd,
		input rs1,
		input rs2,
		input a,
		input b,
		input imm,
		input pc
	);
endinterface

//--- hdl/core_pkg.sv
package core_pkg;

	typedef logic [63:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// OP_NONE is a bubble
	typedef enum logic [3:0] {
		OP_NONE,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_ADDI,
		OP_LUI,
		OP_LD,
		OP_SD,
		OP_BEQ,
		OP_JAL
	} op_t;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t rs2;
		reg_addr_t rs1;
		logic [2:0] funct3;
		reg_addr_t rd;
		logic [6:0] opcode;
	} r_view_t;

	// store and branch layout
	typedef struct packed {
		logic [6:0] imm_hi;
		reg_addr_t rs2;
		reg_addr_t rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_view_t;

	typedef union packed {
		r_view_t r_fields;
		s_view_t s_fields;
	} instr_u;

endpackage

//--- hdl/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define CORE_RESET_PC 64'h0

// major opcodes
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111

`define F3_ADD_SUB 3'b000
`define F3_XOR     3'b100
`define F3_OR      3'b110
`define F3_AND     3'b111
`define F3_DOUBLE  3'b011
`define F3_BEQ     3'b000

`define F7_BASE 7'b0000000
`define F7_SUB  7'b0100000

`endif
